// File: filelist.f
hw/isa_pkg.sv
hw/ieu_pkg.sv
hw/ieu_id_if.sv
hw/ieu_ctl_if.sv
hw/ieu_id.sv
hw/ieu_alu.sv
hw/ieu_ctl.sv
hw/ieu_wb.sv
hw/ieu.sv
verif/tb_ieu.sv

// File: hw/ieu.sv
// Integer execution unit top level connecting decode, the two execute units and write-back.
`timescale 1ns/1ps

module ieu (
    input  logic             clk,
    input  logic             i_rst_n,
    input  isa_pkg::opcode_t i_opcode,
    input  ieu_pkg::addr_t   i_iaddr,
    input  isa_pkg::insn_t   i_insn,
    input  ieu_pkg::data_t   i_src_a,
    input  ieu_pkg::data_t   i_src_b,
    input  ieu_pkg::tag_t    i_tag,
    input  logic             i_valid,
    output ieu_pkg::data_t   o_result,
    output logic             o_redirect,
    output ieu_pkg::addr_t   o_target,
    output ieu_pkg::tag_t    o_tag,
    output logic             o_valid
);
    import isa_pkg::*;
    import ieu_pkg::*;

    data_t alu_result;

    ieu_id_if  id_bus ();
    ieu_ctl_if ctl_bus ();

    ieu_id u_id (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_opcode (i_opcode),
        .i_iaddr  (i_iaddr),
        .i_insn   (i_insn),
        .i_src_a  (i_src_a),
        .i_src_b  (i_src_b),
        .i_tag    (i_tag),
        .i_valid  (i_valid),
        .o_dec    (id_bus.dec)
    );

    ieu_alu u_alu (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_dec    (id_bus.exe),
        .o_result (alu_result)
    );

    ieu_ctl u_ctl (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_dec   (id_bus.exe),
        .o_ctl   (ctl_bus.src)
    );

    ieu_wb u_wb (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_alu_result (alu_result),
        .i_ctl        (ctl_bus.dst),
        .o_result     (o_result),
        .o_redirect   (o_redirect),
        .o_target     (o_target),
        .o_tag        (o_tag),
        .o_valid      (o_valid)
    );

endmodule

// File: hw/ieu_alu.sv
// Registered ALU for add, subtract, shifts, logic operations and compares.
`timescale 1ns/1ps

module ieu_alu (
    input  logic           clk,
    input  logic           i_rst_n,
    ieu_id_if.exe          i_dec,
    output ieu_pkg::data_t o_result
);
    import ieu_pkg::*;

    data_t sum;
    data_t diff;
    logic  lt_s;
    logic  lt_u;
    logic  eq;
    data_t alu_out;

    assign sum  = i_dec.src_a + i_dec.src_b;
    assign diff = i_dec.src_a - i_dec.src_b;
    assign lt_s = $signed(i_dec.src_a) < $signed(i_dec.src_b);
    assign lt_u = i_dec.src_a < i_dec.src_b;
    assign eq   = i_dec.src_a == i_dec.src_b;

    always_comb begin
        case (i_dec.alu_func)
            ALU_FUNC_ADD: alu_out = sum;
            ALU_FUNC_SUB: alu_out = diff;
            ALU_FUNC_SLL: alu_out = i_dec.src_a << i_dec.shamt;
            ALU_FUNC_SRL: alu_out = i_dec.src_a >> i_dec.shamt;
            ALU_FUNC_SRA: alu_out = data_t'($signed(i_dec.src_a) >>> i_dec.shamt);
            ALU_FUNC_XOR: alu_out = i_dec.src_a ^ i_dec.src_b;
            ALU_FUNC_OR:  alu_out = i_dec.src_a | i_dec.src_b;
            ALU_FUNC_AND: alu_out = i_dec.src_a & i_dec.src_b;
            // Compares land in bit 0 with the upper bits cleared.
            ALU_FUNC_LT:  alu_out = data_t'(lt_s);
            ALU_FUNC_LTU: alu_out = data_t'(lt_u);
            ALU_FUNC_EQ:  alu_out = data_t'(eq);
            ALU_FUNC_NE:  alu_out = data_t'(!eq);
            ALU_FUNC_GE:  alu_out = data_t'(!lt_s);
            ALU_FUNC_GEU: alu_out = data_t'(!lt_u);
            default:      alu_out = sum;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_result <= '0;
        end else if (i_dec.valid) begin
            o_result <= alu_out;
        end
    end

endmodule

// File: hw/ieu_ctl.sv
// Registered control-flow unit producing the link address and the branch target.
`timescale 1ns/1ps

module ieu_ctl (
    input  logic   clk,
    input  logic   i_rst_n,
    ieu_id_if.exe  i_dec,
    ieu_ctl_if.src o_ctl
);
    import ieu_pkg::*;

    addr_t link_d;
    addr_t target_d;

    assign link_d   = i_dec.iaddr + addr_t'(INSN_BYTES);
    assign target_d = i_dec.iaddr + addr_t'(i_dec.imm_b);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_ctl.valid <= 1'b0;
            o_ctl.jmp   <= 1'b0;
            o_ctl.br    <= 1'b0;
        end else begin
            o_ctl.valid <= i_dec.valid;
            o_ctl.jmp   <= i_dec.valid & i_dec.jmp;
            o_ctl.br    <= i_dec.valid & i_dec.br;
        end
    end

    // Link and target ride next to the ALU result of the same instruction.
    always_ff @(posedge clk) begin
        if (i_dec.valid) begin
            o_ctl.link   <= link_d;
            o_ctl.target <= target_d;
            o_ctl.tag    <= i_dec.tag;
        end
    end

endmodule

// File: hw/ieu_ctl_if.sv
// Control-flow unit outputs carried to the write-back stage.
`timescale 1ns/1ps

interface ieu_ctl_if;
    import ieu_pkg::*;

    addr_t link;
    addr_t target;
    tag_t  tag;
    logic  jmp;
    logic  br;
    logic  valid;

    modport src (
        output link, target, tag, jmp, br, valid
    );

    modport dst (
        input link, target, tag, jmp, br, valid
    );

endinterface

// File: hw/ieu_id.sv
// Execution unit decode stage with immediates, ALU function, operand select and output register.
`timescale 1ns/1ps

module ieu_id (
    input  logic             clk,
    input  logic             i_rst_n,
    input  isa_pkg::opcode_t i_opcode,
    input  ieu_pkg::addr_t   i_iaddr,
    input  isa_pkg::insn_t   i_insn,
    input  ieu_pkg::data_t   i_src_a,
    input  ieu_pkg::data_t   i_src_b,
    input  ieu_pkg::tag_t    i_tag,
    input  logic             i_valid,
    ieu_id_if.dec            o_dec
);
    import isa_pkg::*;
    import ieu_pkg::*;

    logic [FUNCT3_MSB-FUNCT3_LSB:0] funct3;
    logic                           alt;

    data_t imm_i;
    data_t imm_b;
    data_t imm_u;
    data_t imm_j;

    alu_func_t alu_func_arith;
    alu_func_t alu_func_cmp;
    logic      cmp_legal;

    alu_func_t alu_func_d;
    data_t     src_a_d;
    data_t     src_b_d;
    shamt_t    shamt_d;
    logic      jmp_d;
    logic      br_d;

    assign funct3 = i_insn[FUNCT3_MSB:FUNCT3_LSB];
    assign alt    = i_insn[ALT_BIT];

    assign imm_i = {{(DATA_W-12){i_insn[SIGN_BIT]}}, i_insn[IMM_I_MSB:IMM_I_LSB]};
    assign imm_b = {{(DATA_W-13){i_insn[SIGN_BIT]}}, i_insn[31], i_insn[7],
                    i_insn[30:25], i_insn[11:8], 1'b0};
    assign imm_u = {i_insn[IMM_U_MSB:IMM_U_LSB], 12'b0};
    assign imm_j = {{(DATA_W-21){i_insn[SIGN_BIT]}}, i_insn[31], i_insn[19:12],
                    i_insn[20], i_insn[30:21], 1'b0};

    // Register and immediate forms share one funct3 table. Only OP turns ADD into SUB.
    always_comb begin
        case (funct3)
            3'b000:  alu_func_arith = (alt && i_opcode == OPCODE_OP) ? ALU_FUNC_SUB
                                                                     : ALU_FUNC_ADD;
            3'b001:  alu_func_arith = ALU_FUNC_SLL;
            3'b010:  alu_func_arith = ALU_FUNC_LT;
            3'b011:  alu_func_arith = ALU_FUNC_LTU;
            3'b100:  alu_func_arith = ALU_FUNC_XOR;
            3'b101:  alu_func_arith = alt ? ALU_FUNC_SRA : ALU_FUNC_SRL;
            3'b110:  alu_func_arith = ALU_FUNC_OR;
            default: alu_func_arith = ALU_FUNC_AND;
        endcase
    end

    // Branch compares. Funct3 values 010 and 011 are not branches.
    always_comb begin
        cmp_legal = 1'b1;
        case (funct3)
            3'b000:  alu_func_cmp = ALU_FUNC_EQ;
            3'b001:  alu_func_cmp = ALU_FUNC_NE;
            3'b100:  alu_func_cmp = ALU_FUNC_LT;
            3'b101:  alu_func_cmp = ALU_FUNC_GE;
            3'b110:  alu_func_cmp = ALU_FUNC_LTU;
            3'b111:  alu_func_cmp = ALU_FUNC_GEU;
            default: begin
                alu_func_cmp = ALU_FUNC_ADD;
                cmp_legal    = 1'b0;
            end
        endcase
    end

    // Anything not listed falls back to an ADD of the two register operands.
    always_comb begin
        alu_func_d = ALU_FUNC_ADD;
        src_a_d    = i_src_a;
        src_b_d    = i_src_b;
        shamt_d    = i_insn[RS2_MSB:RS2_LSB];
        jmp_d      = 1'b0;
        br_d       = 1'b0;
        case (i_opcode)
            OPCODE_OPIMM: begin
                alu_func_d = alu_func_arith;
                src_b_d    = imm_i;
            end
            OPCODE_OP: begin
                alu_func_d = alu_func_arith;
                shamt_d    = i_src_b[SHAMT_W-1:0];
            end
            OPCODE_BRANCH: begin
                alu_func_d = alu_func_cmp;
                br_d       = cmp_legal;
            end
            OPCODE_LUI: begin
                src_a_d = '0;
                src_b_d = imm_u;
            end
            OPCODE_AUIPC: begin
                src_a_d = data_t'(i_iaddr);
                src_b_d = imm_u;
            end
            OPCODE_JAL: begin
                src_a_d = data_t'(i_iaddr);
                src_b_d = imm_j;
                jmp_d   = 1'b1;
            end
            OPCODE_JALR: begin
                src_b_d = imm_i;
                jmp_d   = 1'b1;
            end
            default: begin
                alu_func_d = ALU_FUNC_ADD;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_dec.valid <= 1'b0;
            o_dec.jmp   <= 1'b0;
            o_dec.br    <= 1'b0;
        end else begin
            o_dec.valid <= i_valid;
            o_dec.jmp   <= i_valid & jmp_d;
            o_dec.br    <= i_valid & br_d;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_dec.alu_func <= alu_func_d;
            o_dec.src_a    <= src_a_d;
            o_dec.src_b    <= src_b_d;
            o_dec.imm_b    <= imm_b;
            o_dec.shamt    <= shamt_d;
            o_dec.iaddr    <= i_iaddr;
            o_dec.tag      <= i_tag;
        end
    end

endmodule

// File: hw/ieu_id_if.sv
// Decoded instruction bundle from the decode stage to the ALU and control-flow unit.
`timescale 1ns/1ps

interface ieu_id_if;
    import ieu_pkg::*;

    alu_func_t alu_func;
    data_t     src_a;
    data_t     src_b;
    data_t     imm_b;
    shamt_t    shamt;
    addr_t     iaddr;
    tag_t      tag;
    logic      jmp;
    logic      br;
    logic      valid;

    modport dec (
        output alu_func, src_a, src_b, imm_b, shamt, iaddr, tag, jmp, br, valid
    );

    modport exe (
        input alu_func, src_a, src_b, imm_b, shamt, iaddr, tag, jmp, br, valid
    );

endinterface

// File: hw/ieu_pkg.sv
// Execution unit types for data, addresses, tags and ALU functions, with their widths.
package ieu_pkg;

    localparam int DATA_W  = 32;
    localparam int ADDR_W  = 32;
    localparam int TAG_W   = 6;
    localparam int SHAMT_W = 5;

    // Byte distance from an instruction to the next one, used for the link address.
    localparam int INSN_BYTES = 4;

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [SHAMT_W-1:0] shamt_t;

    // Functions the ALU can perform. The compares return 1 or 0 in bit 0.
    typedef enum logic [3:0] {
        ALU_FUNC_ADD,
        ALU_FUNC_SUB,
        ALU_FUNC_SLL,
        ALU_FUNC_SRL,
        ALU_FUNC_SRA,
        ALU_FUNC_XOR,
        ALU_FUNC_OR,
        ALU_FUNC_AND,
        ALU_FUNC_LT,
        ALU_FUNC_LTU,
        ALU_FUNC_EQ,
        ALU_FUNC_NE,
        ALU_FUNC_GE,
        ALU_FUNC_GEU
    } alu_func_t;

endpackage

// File: hw/ieu_wb.sv
// Write-back stage merging the ALU result and control-flow outputs into result and redirect.
`timescale 1ns/1ps

module ieu_wb (
    input  logic           clk,
    input  logic           i_rst_n,
    input  ieu_pkg::data_t i_alu_result,
    ieu_ctl_if.dst         i_ctl,
    output ieu_pkg::data_t o_result,
    output logic           o_redirect,
    output ieu_pkg::addr_t o_target,
    output ieu_pkg::tag_t  o_tag,
    output logic           o_valid
);
    import ieu_pkg::*;

    data_t result_d;
    logic  redirect_d;
    addr_t target_d;

    always_comb begin
        if (i_ctl.jmp) begin
            // The ALU sum is the jump destination, forced to an even address.
            result_d   = data_t'(i_ctl.link);
            redirect_d = 1'b1;
            target_d   = addr_t'({i_alu_result[DATA_W-1:1], 1'b0});
        end else if (i_ctl.br) begin
            result_d   = '0;
            redirect_d = i_alu_result[0];
            target_d   = i_ctl.target;
        end else begin
            result_d   = i_alu_result;
            redirect_d = 1'b0;
            target_d   = i_ctl.target;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_valid    <= 1'b0;
            o_redirect <= 1'b0;
        end else begin
            o_valid    <= i_ctl.valid;
            o_redirect <= i_ctl.valid & redirect_d;
        end
    end

    always_ff @(posedge clk) begin
        if (i_ctl.valid) begin
            o_result <= result_d;
            o_target <= target_d;
            o_tag    <= i_ctl.tag;
        end
    end

endmodule

// File: hw/isa_pkg.sv
// RV32I instruction encoding with the major opcodes, field positions and instruction word type.
package isa_pkg;

    localparam int INSN_W = 32;

    // Bit positions of the fields the execution unit decodes.
    localparam int OPCODE_MSB = 6;
    localparam int OPCODE_LSB = 0;
    localparam int FUNCT3_MSB = 14;
    localparam int FUNCT3_LSB = 12;
    localparam int RS2_MSB    = 24;
    localparam int RS2_LSB    = 20;
    localparam int IMM_I_MSB  = 31;
    localparam int IMM_I_LSB  = 20;
    localparam int IMM_U_MSB  = 31;
    localparam int IMM_U_LSB  = 12;

    // Bit 30 selects SUB over ADD and SRA over SRL.
    localparam int ALT_BIT = 30;

    // The sign of every immediate sits in the top bit.
    localparam int SIGN_BIT = 31;

    typedef logic [INSN_W-1:0] insn_t;

    typedef enum logic [OPCODE_MSB-OPCODE_LSB:0] {
        OPCODE_OPIMM  = 7'b0010011,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_OP     = 7'b0110011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_JAL    = 7'b1101111
    } opcode_t;

endpackage

// File: verif/tb_ieu.sv
// Integer execution unit testbench with directed and random instructions and a reference model.
`timescale 1ns/1ps

module tb_ieu;
    import isa_pkg::*;
    import ieu_pkg::*;

    localparam int          CLK_PERIOD = 20;
    localparam int          RST_CYCLES = 4;
    localparam int          LATENCY    = 3;
    localparam int          NUM_RAND   = 300;
    localparam int          MAX_GAP    = 3;
    localparam int          NUM_ISSUE  = 56 + NUM_RAND;
    localparam int          WDOG_CYCLES = NUM_ISSUE * (MAX_GAP + 1) + RST_CYCLES + 50;
    localparam logic [31:0] SEED       = 32'h477c_0592;

    typedef struct packed {
        data_t       result;
        logic        redirect;
        addr_t       target;
        logic        chk_target;
        tag_t        tag;
        logic [31:0] cyc;
    } exp_t;

    logic    clk;
    logic    i_rst_n;
    opcode_t i_opcode;
    addr_t   i_iaddr;
    insn_t   i_insn;
    data_t   i_src_a;
    data_t   i_src_b;
    tag_t    i_tag;
    logic    i_valid;
    data_t   o_result;
    logic    o_redirect;
    addr_t   o_target;
    tag_t    o_tag;
    logic    o_valid;

    exp_t        exp_q [$];
    tag_t        tag_cnt;
    logic [31:0] cycle_cnt;
    int          err_value;
    int          err_other;

    // The last entry is a load opcode, which the unit treats as an ADD.
    opcode_t op_list [8] = '{OPCODE_OP, OPCODE_OPIMM, OPCODE_BRANCH, OPCODE_LUI,
                             OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR, opcode_t'(7'b0000011)};

    ieu i_ieu (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_opcode   (i_opcode),
        .i_iaddr    (i_iaddr),
        .i_insn     (i_insn),
        .i_src_a    (i_src_a),
        .i_src_b    (i_src_b),
        .i_tag      (i_tag),
        .i_valid    (i_valid),
        .o_result   (o_result),
        .o_redirect (o_redirect),
        .o_target   (o_target),
        .o_tag      (o_tag),
        .o_valid    (o_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Expected write-back from the RV32I rules for one instruction.
    function automatic exp_t ref_exec(opcode_t op, insn_t insn, data_t a, data_t b, addr_t pc);
        exp_t       e;
        logic [2:0] f3;
        logic       alt;
        logic       cond;
        data_t      imm_i;
        data_t      imm_b;
        data_t      imm_u;
        data_t      imm_j;
        data_t      opb;
        shamt_t     sh;
        f3    = insn[14:12];
        alt   = insn[30];
        imm_i = {{20{insn[31]}}, insn[31:20]};
        imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
        imm_u = {insn[31:12], 12'b0};
        imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
        e = '0;
        e.result = a + b;
        case (op)
            OPCODE_OP, OPCODE_OPIMM: begin
                opb = (op == OPCODE_OP) ? b : imm_i;
                sh  = (op == OPCODE_OP) ? b[4:0] : insn[24:20];
                case (f3)
                    3'd0:    e.result = (alt && op == OPCODE_OP) ? a - opb : a + opb;
                    3'd1:    e.result = a << sh;
                    3'd2:    e.result = data_t'($signed(a) < $signed(opb));
                    3'd3:    e.result = data_t'(a < opb);
                    3'd4:    e.result = a ^ opb;
                    3'd5:    e.result = alt ? data_t'($signed(a) >>> sh) : a >> sh;
                    3'd6:    e.result = a | opb;
                    default: e.result = a & opb;
                endcase
            end
            OPCODE_BRANCH: begin
                case (f3)
                    3'd0:    cond = (a == b);
                    3'd1:    cond = (a != b);
                    3'd4:    cond = ($signed(a) < $signed(b));
                    3'd5:    cond = ($signed(a) >= $signed(b));
                    3'd6:    cond = (a < b);
                    default: cond = (a >= b);
                endcase
                // Funct3 010 and 011 are no branch and stay a plain ADD.
                if (f3 != 3'd2 && f3 != 3'd3) begin
                    e.result     = '0;
                    e.redirect   = cond;
                    e.target     = pc + imm_b;
                    e.chk_target = 1'b1;
                end
            end
            OPCODE_LUI:   e.result = imm_u;
            OPCODE_AUIPC: e.result = pc + imm_u;
            OPCODE_JAL, OPCODE_JALR: begin
                e.result     = pc + 4;
                e.redirect   = 1'b1;
                e.target     = (op == OPCODE_JAL) ? pc + imm_j : a + imm_i;
                e.target[0]  = 1'b0;
                e.chk_target = 1'b1;
            end
            default: e.result = a + b;
        endcase
        return e;
    endfunction

    task automatic check_data(string name, data_t got, data_t exp);
        if (got !== exp) begin
            err_value++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            err_value++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_tag(string name, tag_t got, tag_t exp);
        if (got !== exp) begin
            err_value++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            err_value++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic insn_t make_insn(opcode_t op, logic [2:0] f3, logic alt);
        insn_t insn;
        insn        = $urandom;
        insn[6:0]   = op;
        insn[14:12] = f3;
        insn[30]    = alt;
        return insn;
    endfunction

    // Equal operands now and then so EQ and GE see their true case.
    function automatic data_t pick_b(data_t a);
        if ($urandom_range(0, 3) == 0) begin
            return a;
        end
        return $urandom;
    endfunction

    task automatic issue(opcode_t op, insn_t insn, data_t a, data_t b);
        addr_t pc;
        pc      = $urandom;
        pc[1:0] = 2'b00;
        @(posedge clk);
        i_opcode <= op;
        i_insn   <= insn;
        i_src_a  <= a;
        i_src_b  <= b;
        i_iaddr  <= pc;
        i_tag    <= tag_cnt;
        i_valid  <= 1'b1;
        tag_cnt++;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            i_valid <= 1'b0;
        end
    endtask

    // Inputs and outputs are both stable at the falling edge.
    always @(negedge clk) begin : compare
        exp_t e;
        cycle_cnt = cycle_cnt + 1;
        if (i_rst_n) begin
            if (o_valid) begin
                if (exp_q.size() == 0) begin
                    err_other++;
                    $display("Output with tag %h appeared with no instruction outstanding", o_tag);
                end else begin
                    e = exp_q.pop_front();
                    if (cycle_cnt - e.cyc != LATENCY) begin
                        err_other++;
                        $display("Tag %h came out %0d cycles after issue instead of %0d",
                                 e.tag, cycle_cnt - e.cyc, LATENCY);
                    end
                    check_tag("o_tag", o_tag, e.tag);
                    check_data("o_result", o_result, e.result);
                    check_bit("o_redirect", o_redirect, e.redirect);
                    if (e.chk_target) begin
                        check_addr("o_target", o_target, e.target);
                    end
                end
            end else begin
                check_bit("o_valid", o_valid, 1'b0);
                check_bit("o_redirect", o_redirect, 1'b0);
            end
            if (i_valid) begin
                e     = ref_exec(i_opcode, i_insn, i_src_a, i_src_b, i_iaddr);
                e.tag = i_tag;
                e.cyc = cycle_cnt;
                exp_q.push_back(e);
            end
        end
    end

    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles with %0d results still outstanding",
                 WDOG_CYCLES, exp_q.size());
        $display("Regression failed");
        $finish;
    end

    initial begin
        data_t   a;
        opcode_t op;
        void'($urandom(SEED));
        i_rst_n   = 1'b0;
        i_opcode  = OPCODE_OP;
        i_iaddr   = '0;
        i_insn    = '0;
        i_src_a   = '0;
        i_src_b   = '0;
        i_tag     = '0;
        i_valid   = 1'b0;
        tag_cnt   = '0;
        cycle_cnt = '0;
        err_value = 0;
        err_other = 0;
        repeat (RST_CYCLES) @(posedge clk);
        i_rst_n <= 1'b1;
        idle(3);

        for (int k = 0; k < 32; k++) begin
            op = (k < 16) ? OPCODE_OP : OPCODE_OPIMM;
            a  = $urandom;
            issue(op, make_insn(op, 3'(k % 8), k[3]), a, pick_b(a));
        end
        for (int k = 0; k < 16; k++) begin
            a = $urandom;
            issue(OPCODE_BRANCH, make_insn(OPCODE_BRANCH, 3'(k % 8), 1'b0), a,
                  (k < 8) ? a : data_t'($urandom));
        end
        // Two each of LUI, AUIPC, JAL and JALR.
        for (int k = 0; k < 8; k++) begin
            op = op_list[3 + k / 2];
            issue(op, make_insn(op, 3'($urandom), 1'($urandom)), $urandom, $urandom);
        end

        for (int k = 0; k < NUM_RAND; k++) begin
            op = op_list[$urandom_range(0, 7)];
            a  = $urandom;
            issue(op, make_insn(op, 3'($urandom), 1'($urandom)), a, pick_b(a));
            if ($urandom_range(0, 1) == 1) begin
                idle($urandom_range(1, MAX_GAP));
            end
        end
        idle(1);

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        idle(8);

        $display("Checks done with %0d value errors and %0d other errors", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
